/* common/ebox_cfg.svh */
`ifndef EBOX_CFG_SVH
`define EBOX_CFG_SVH

// Data path word, PDP-10 bit order 0..35
`define EBOX_WORD 36

// Diagnostic select from console ds or magic bits 2..8
`define EBOX_DIAG_W 7

// Readback lane on the bus data
`define EBOX_RB_LSB 24
`define EBOX_RB_W 5

// Diagnostic function codes
`define EBOX_DIAG_LD076 7'o076

`endif

/* common/ebox_pkg.sv */
`default_nettype none
`include "ebox_cfg.svh"

package eboxPkg;

  typedef enum logic [2:0] {
    dispNone,
    dispAread,
    dispReturn,
    dispNicond,
    dispMul,
    dispDiv,
    dispNorm,
    dispEaMod
  } dispCode_t;

  typedef enum logic [3:0] {
    specNone,
    specInhCry18,
    specMqShift,
    specClrFpd,
    specLoadPc,
    specGenCry18,
    specStackUpdate,
    specArlInd,
    specFlagCtl,
    specSaveFlags,
    specAdLong,
    specMtrCtl
  } specCode_t;

  // Microword fields of the control slice.
  // arSel: bit 0 holds AR left (right half only), bits 1..2 are the select code.
  // arxSel: bit 0 clears ARX, bits 1..2 are the select code.
  typedef struct packed {
    dispCode_t  disp;
    specCode_t  spec;
    logic [0:2] cond;
    logic       condEn;
    logic [0:8] magic;
    logic [0:2] arSel;
    logic [0:2] arxSel;
    logic       mqEn;
  } cramWord_t;

  // Select codes: 0 hold, 1 adIn, 2 memIn or ebusIn (MQ shifts), 3 zero
  typedef struct packed {
    logic [1:0] arlSel;
    logic [1:0] arrSel;
    logic [1:0] arxSel;
    logic [1:0] mqSel;
    logic       arlLoad;
    logic       arrLoad;
    logic       arxLoad;
    logic       arlClr;
    logic       arrClr;
    logic       arxClr;
    logic       mqClr;
    logic       adLong;
    logic       genCry18;
    logic       dispRet;
    logic       loadPc;
    logic       specSaveFlags;
    logic       specClrFpd;
    logic       specMqShift;
    logic       diagArLoad;
  } ctlSig_t;

  typedef struct packed {
    logic [0:`EBOX_DIAG_W-1] diag;
    logic                    readStrobe;
    logic                    consoleControl;
    logic                    diagArLoad;
    logic                    ld076;
    logic                    ebusXferEn;
  } diagSig_t;

  // Loaded from bus data bits 24..28 by function 076
  typedef struct packed {
    logic memReset;
    logic chanClkStop;
    logic ldEbusReg;
    logic forceExtend;
    logic diag4;
  } diagReg_t;

endpackage

`default_nettype wire

/* ctl/ctlDecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module ctlDecode (
  input  eboxPkg::cramWord_t cram,
  input  eboxPkg::diagSig_t  diag,
  input  logic               respMbox,
  input  logic               loadAr,
  input  logic               loadArx,
  input  logic               shortStack,
  output eboxPkg::ctlSig_t   ctl
);

  logic       condLoadL;
  logic       condLoadR;
  logic       condArClr;
  logic       condArxClr;
  logic       condInd;
  logic       condRegCtl;
  logic       indMode;
  logic [0:2] arField;
  logic [1:0] arCode;
  logic [1:0] arxCode;
  logic       forceAr;
  logic       memArx;
  logic       mathShift;
  logic       arlLoadReq;
  logic       arrLoadReq;
  logic       arxLoadReq;

  // Condition field, only with condEn
  always_comb begin
    condLoadL  = cram.condEn && (cram.cond == 3'd1 || cram.cond == 3'd3);
    condLoadR  = cram.condEn && (cram.cond == 3'd2 || cram.cond == 3'd3);
    condArClr  = cram.condEn && (cram.cond == 3'd4);
    condArxClr = cram.condEn && (cram.cond == 3'd5);
    condInd    = cram.condEn && (cram.cond == 3'd6);
    condRegCtl = cram.condEn && (cram.cond == 3'd7);
  end

  // Indirect mode hands the AR select over to magic 6..8
  assign indMode = condInd || (cram.spec == eboxPkg::specArlInd);
  assign arField = indMode ? cram.magic[6:8] : cram.arSel;
  assign arCode  = arField[1:2];
  assign arxCode = cram.arxSel[1:2];

  // Memory response or diagnostic load takes over the AR select
  assign forceAr = (respMbox && loadAr) || diag.diagArLoad;
  assign memArx  = respMbox && loadArx;

  assign mathShift = (cram.spec == eboxPkg::specMqShift) ||
                     (cram.disp == eboxPkg::dispMul) ||
                     (cram.disp == eboxPkg::dispDiv);

  assign arlLoadReq = forceAr || condLoadL || (arCode != 2'd0 && !arField[0]);
  assign arrLoadReq = forceAr || condLoadR || (arCode != 2'd0);
  assign arxLoadReq = memArx || (arxCode != 2'd0);

  always_comb begin
    ctl = '0;

    ctl.arlClr = condArClr;
    ctl.arrClr = condArClr;
    ctl.arxClr = (indMode ? cram.magic[3] : condArxClr) || cram.arxSel[0];
    ctl.mqClr  = indMode && cram.magic[2];

    // A plain condition load with a hold code takes the adder
    if (forceAr) begin
      ctl.arlSel = 2'd2;
      ctl.arrSel = 2'd2;
    end else begin
      ctl.arlSel = (arCode == 2'd0) ? 2'd1 : arCode;
      ctl.arrSel = (arCode == 2'd0) ? 2'd1 : arCode;
    end
    ctl.arxSel = memArx ? 2'd2 : arxCode;

    if (condRegCtl) begin
      ctl.mqSel = cram.magic[7:8];
    end else if (mathShift) begin
      ctl.mqSel = 2'd2;
    end else begin
      ctl.mqSel = {1'b0, cram.mqEn};
    end

    // Clear wins over load
    ctl.arlLoad = arlLoadReq && !ctl.arlClr;
    ctl.arrLoad = arrLoadReq && !ctl.arrClr;
    ctl.arxLoad = arxLoadReq && !ctl.arxClr;

    ctl.adLong = (cram.disp == eboxPkg::dispMul) ||
                 (cram.disp == eboxPkg::dispDiv) ||
                 (cram.disp == eboxPkg::dispNorm) ||
                 (cram.spec == eboxPkg::specAdLong) ||
                 (cram.spec == eboxPkg::specMqShift);

    // Stack update carries only on a short stack
    ctl.genCry18 = (cram.spec == eboxPkg::specGenCry18) ||
                   ((cram.spec == eboxPkg::specStackUpdate) && shortStack);

    ctl.dispRet       = cram.disp == eboxPkg::dispReturn;
    ctl.loadPc        = (cram.spec == eboxPkg::specLoadPc) ||
                        (cram.disp == eboxPkg::dispNicond);
    ctl.specSaveFlags = cram.spec == eboxPkg::specSaveFlags;
    ctl.specClrFpd    = cram.spec == eboxPkg::specClrFpd;
    ctl.specMqShift   = cram.spec == eboxPkg::specMqShift;
    ctl.diagArLoad    = diag.diagArLoad;
  end

endmodule

`default_nettype wire

/* ctl/ctlDiag.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module ctlDiag (
  input  logic                    CTL,
  input  logic                    reset,
  input  eboxPkg::cramWord_t      cram,
  input  eboxPkg::ctlSig_t        ctl,
  input  logic [0:`EBOX_DIAG_W-1] ds,
  input  logic                    diagStrobe,
  input  logic [0:`EBOX_WORD-1]   ebusIn,
  output eboxPkg::diagSig_t       diag,
  output logic [0:`EBOX_WORD-1]   ebusOut,
  output logic                    ebusDriving,
  output logic                    loadPc
);

  eboxPkg::diagReg_t diagReg;

  logic                    consoleControl;
  logic [0:`EBOX_DIAG_W-1] diagSel;
  logic                    readStrobe;
  logic                    en1xx;
  logic                    read10x;
  logic                    ld076;
  logic                    arLoad;
  logic [0:`EBOX_RB_W-1]   rbGroup;

  // Console owns the function when ds 0 or 1 is set
  assign consoleControl = ds[0] | ds[1];
  assign diagSel        = consoleControl ? ds : cram.magic[2:8];
  assign readStrobe     = consoleControl ? diagStrobe : (diagStrobe & cram.condEn);

  assign en1xx   = diagSel[0] & readStrobe;
  assign read10x = en1xx && (diagSel[1:3] == 3'b000);
  assign ld076   = diagStrobe && (ds == `EBOX_DIAG_LD076);
  assign arLoad  = en1xx && (&ds[1:3]) && (&diagSel[4:6]);

  always_comb begin
    diag.diag           = diagSel;
    diag.readStrobe     = readStrobe;
    diag.consoleControl = consoleControl;
    diag.diagArLoad     = arLoad;
    diag.ld076          = ld076;
    diag.ebusXferEn     = read10x;
  end

  // Readback groups selected by diag 4..6
  always_comb begin
    case (diagSel[4:6])
      3'd0: rbGroup = {ctl.specMqShift, ctl.specSaveFlags, ctl.arlSel[1],
                       ctl.arrLoad, ctl.arlLoad};
      3'd1: rbGroup = {ctl.specClrFpd, cram.spec == eboxPkg::specMtrCtl, ctl.arlSel[0],
                       ctl.arrLoad, ctl.arlLoad};
      3'd2: rbGroup = {ctl.genCry18, ctl.diagArLoad, ctl.arrSel[1],
                       ctl.mqSel[1], ctl.arxLoad};
      3'd3: rbGroup = {cram.spec == eboxPkg::specStackUpdate, ctl.dispRet, ctl.arrSel[0],
                       ctl.mqSel[0], ctl.arxClr};
      3'd4: rbGroup = {cram.spec == eboxPkg::specFlagCtl, ctl.loadPc, ctl.arxSel[1],
                       ctl.mqClr, ctl.arlClr};
      3'd5: rbGroup = {diagReg.chanClkStop, diagReg.forceExtend, ctl.arxSel[0],
                       ctl.mqClr, ctl.arlClr};
      3'd6: rbGroup = {ctl.adLong, diagReg.diag4, ctl.arxSel[1],
                       cram.mqEn, ctl.arrClr};
      default: rbGroup = {cram.spec == eboxPkg::specInhCry18, diagReg.memReset,
                          ctl.arxSel[0], diagReg.ldEbusReg,
                          cram.disp == eboxPkg::dispAread};
    endcase
  end

  always_ff @(posedge CTL) begin
    if (reset) begin
      diagReg     <= '0;
      ebusOut     <= '0;
      ebusDriving <= 1'b0;
      loadPc      <= 1'b0;
    end else begin
      if (ld076) begin
        diagReg <= ebusIn[`EBOX_RB_LSB +: `EBOX_RB_W];
      end

      ebusDriving <= read10x;
      ebusOut     <= '0;
      if (read10x) begin
        ebusOut[`EBOX_RB_LSB +: `EBOX_RB_W] <= rbGroup;
      end

      // Single-cycle pulse, a held request does not stretch it
      loadPc <= ctl.loadPc & ~loadPc;
    end
  end

endmodule

`default_nettype wire

/* hdl/arDatapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module arDatapath (
  input  logic                  CTL,
  input  logic                  reset,
  input  eboxPkg::ctlSig_t      ctl,
  input  logic [0:`EBOX_WORD-1] adIn,
  input  logic [0:`EBOX_WORD-1] memIn,
  input  logic [0:`EBOX_WORD-1] ebusIn,
  output logic [0:`EBOX_WORD-1] ar,
  output logic [0:`EBOX_WORD-1] arx,
  output logic [0:`EBOX_WORD-1] mq
);

  localparam int Half = `EBOX_WORD / 2;

  logic [0:`EBOX_WORD-1] arMemSrc;
  logic [0:`EBOX_WORD-1] arlNext;
  logic [0:`EBOX_WORD-1] arrNext;
  logic [0:`EBOX_WORD-1] arxNext;

  // Common select decode: hold, adder, memory, zero
  function automatic logic [0:`EBOX_WORD-1] pickWord(
    input logic [1:0]            sel,
    input logic [0:`EBOX_WORD-1] hold,
    input logic [0:`EBOX_WORD-1] ad,
    input logic [0:`EBOX_WORD-1] mem
  );
    logic [0:`EBOX_WORD-1] res;
    case (sel)
      2'd0: res = hold;
      2'd1: res = ad;
      2'd2: res = mem;
      default: res = '0;
    endcase
    return res;
  endfunction

  // Diagnostic AR load reads the bus instead of memory
  assign arMemSrc = ctl.diagArLoad ? ebusIn : memIn;

  assign arlNext = pickWord(ctl.arlSel, ar, adIn, arMemSrc);
  assign arrNext = pickWord(ctl.arrSel, ar, adIn, arMemSrc);
  assign arxNext = pickWord(ctl.arxSel, arx, adIn, memIn);

  // AR halves load on their own
  always_ff @(posedge CTL) begin
    if (reset || ctl.arlClr) begin
      ar[0 +: Half] <= '0;
    end else if (ctl.arlLoad) begin
      ar[0 +: Half] <= arlNext[0 +: Half];
    end
  end

  always_ff @(posedge CTL) begin
    if (reset || ctl.arrClr) begin
      ar[Half +: Half] <= '0;
    end else if (ctl.arrLoad) begin
      ar[Half +: Half] <= arrNext[Half +: Half];
    end
  end

  always_ff @(posedge CTL) begin
    if (reset || ctl.arxClr) begin
      arx <= '0;
    end else if (ctl.arxLoad) begin
      arx <= arxNext;
    end
  end

  // MQ code 2 shifts left, adder bit 0 enters at bit 35
  always_ff @(posedge CTL) begin
    if (reset || ctl.mqClr) begin
      mq <= '0;
    end else begin
      case (ctl.mqSel)
        2'd0: mq <= mq;
        2'd1: mq <= adIn;
        2'd2: mq <= {mq[1:`EBOX_WORD-1], adIn[0]};
        default: mq <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/eboxCtl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module eboxCtl (
  input  logic                    CTL,
  input  logic                    reset,
  input  eboxPkg::cramWord_t      cram,
  input  logic [0:`EBOX_WORD-1]   adIn,
  input  logic [0:`EBOX_WORD-1]   memIn,
  input  logic                    loadAr,
  input  logic                    loadArx,
  input  logic                    respMbox,
  input  logic                    shortStack,
  input  logic [0:`EBOX_DIAG_W-1] ds,
  input  logic                    diagStrobe,
  input  logic [0:`EBOX_WORD-1]   ebusIn,
  output logic [0:`EBOX_WORD-1]   ar,
  output logic [0:`EBOX_WORD-1]   arx,
  output logic [0:`EBOX_WORD-1]   mq,
  output logic [0:`EBOX_WORD-1]   ebusOut,
  output logic                    ebusDriving,
  output logic                    adLong,
  output logic                    genCry18,
  output logic                    loadPc
);

  eboxPkg::ctlSig_t  ctl;
  eboxPkg::diagSig_t diag;

  ctlDecode ctlDecode_inst (
    .cram       (cram),
    .diag       (diag),
    .respMbox   (respMbox),
    .loadAr     (loadAr),
    .loadArx    (loadArx),
    .shortStack (shortStack),
    .ctl        (ctl)
  );

  ctlDiag ctlDiag_inst (
    .CTL         (CTL),
    .reset       (reset),
    .cram        (cram),
    .ctl         (ctl),
    .ds          (ds),
    .diagStrobe  (diagStrobe),
    .ebusIn      (ebusIn),
    .diag        (diag),
    .ebusOut     (ebusOut),
    .ebusDriving (ebusDriving),
    .loadPc      (loadPc)
  );

  arDatapath arDatapath_inst (
    .CTL    (CTL),
    .reset  (reset),
    .ctl    (ctl),
    .adIn   (adIn),
    .memIn  (memIn),
    .ebusIn (ebusIn),
    .ar     (ar),
    .arx    (arx),
    .mq     (mq)
  );

  assign adLong   = ctl.adLong;
  assign genCry18 = ctl.genCry18;

endmodule

`default_nettype wire

/* verif/eboxCtl_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module eboxCtlAssert (
  input logic                    CTL,
  input logic                    reset,
  input eboxPkg::cramWord_t      cram,
  input logic [0:`EBOX_DIAG_W-1] ds,
  input logic                    diagStrobe,
  input logic                    ebusDriving,
  input logic                    loadPc,
  input logic [0:`EBOX_WORD-1]   ar,
  input logic [0:`EBOX_WORD-1]   arx,
  input logic [0:`EBOX_WORD-1]   mq
);

  logic                    console;
  logic [0:`EBOX_DIAG_W-1] fnSel;
  logic                    readFn;
  logic                    pcReq;

  // Read function 10x and load PC request seen on the top-level inputs
  assign console = ds[0] | ds[1];
  assign fnSel   = console ? ds : cram.magic[2:8];
  assign readFn  = diagStrobe && (console || cram.condEn) && (fnSel[0:3] == 4'b1000);
  assign pcReq   = (cram.spec == eboxPkg::specLoadPc) ||
                   (cram.disp == eboxPkg::dispNicond);

  // Bus driven only in the cycle after a read function
  noReadNoDrive: assert property (@(posedge CTL) disable iff (reset)
    !readFn |=> !ebusDriving)
    else $error("ebusDriving high without a preceding read function");

  loadPcPulse: assert property (@(posedge CTL) disable iff (reset)
    (pcReq && !loadPc) |=> loadPc ##1 !loadPc)
    else $error("loadPc request did not give a one-cycle pulse");

  resetClears: assert property (@(posedge CTL)
    reset |=> (ar == '0 && arx == '0 && mq == '0 && !ebusDriving && !loadPc))
    else $error("registers not cleared by reset");

endmodule

bind eboxCtl eboxCtlAssert eboxCtlAssert_inst (
  .CTL         (CTL),
  .reset       (reset),
  .cram        (cram),
  .ds          (ds),
  .diagStrobe  (diagStrobe),
  .ebusDriving (ebusDriving),
  .loadPc      (loadPc),
  .ar          (ar),
  .arx         (arx),
  .mq          (mq)
);

`default_nettype wire

/* verif/eboxCtlTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ebox_cfg.svh"

module eboxCtlTb;

  localparam int Word = `EBOX_WORD;
  localparam int Half = Word / 2;
  localparam int DriveTimeout = 4;
  localparam int WatchdogNs = 200000;

  // One cycle of DUT inputs
  typedef struct packed {
    eboxPkg::cramWord_t      cram;
    logic [0:Word-1]         adIn;
    logic [0:Word-1]         memIn;
    logic                    loadAr;
    logic                    loadArx;
    logic                    respMbox;
    logic                    shortStack;
    logic [0:`EBOX_DIAG_W-1] ds;
    logic                    diagStrobe;
    logic [0:Word-1]         ebusIn;
  } stim_t;

  logic                    CTL;
  logic                    reset;
  eboxPkg::cramWord_t      cram;
  logic [0:Word-1]         adIn;
  logic [0:Word-1]         memIn;
  logic                    loadAr;
  logic                    loadArx;
  logic                    respMbox;
  logic                    shortStack;
  logic [0:`EBOX_DIAG_W-1] ds;
  logic                    diagStrobe;
  logic [0:Word-1]         ebusIn;
  logic [0:Word-1]         ar;
  logic [0:Word-1]         arx;
  logic [0:Word-1]         mq;
  logic [0:Word-1]         ebusOut;
  logic                    ebusDriving;
  logic                    adLong;
  logic                    genCry18;
  logic                    loadPc;

  stim_t             st;
  stim_t             cur;
  logic [0:Word-1]   arM;
  logic [0:Word-1]   arxM;
  logic [0:Word-1]   mqM;
  logic [0:Word-1]   ebusOutM;
  logic              ebusDrvM;
  logic              loadPcM;
  logic              adLongM;
  logic              genCryM;
  eboxPkg::diagReg_t dregM;
  logic [0:Word-1]   busWord;
  string             testName;
  int                errCount;
  int                timeoutCount;

  eboxCtl eboxCtl_inst (
    .CTL         (CTL),
    .reset       (reset),
    .cram        (cram),
    .adIn        (adIn),
    .memIn       (memIn),
    .loadAr      (loadAr),
    .loadArx     (loadArx),
    .respMbox    (respMbox),
    .shortStack  (shortStack),
    .ds          (ds),
    .diagStrobe  (diagStrobe),
    .ebusIn      (ebusIn),
    .ar          (ar),
    .arx         (arx),
    .mq          (mq),
    .ebusOut     (ebusOut),
    .ebusDriving (ebusDriving),
    .adLong      (adLong),
    .genCry18    (genCry18),
    .loadPc      (loadPc)
  );

  initial begin
    CTL = 1'b0;
    forever #20 CTL = ~CTL;
  end

  function automatic logic [0:Word-1] randWord();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[Word-1:0];
  endfunction

  function automatic logic [0:Word-1] widen(input logic b);
    logic [0:Word-1] r;
    r = '0;
    r[Word-1] = b;
    return r;
  endfunction

  function automatic stim_t randStim();
    stim_t s;
    s = '0;
    s.cram.disp   = eboxPkg::dispCode_t'(3'($urandom_range(0, 7)));
    s.cram.spec   = eboxPkg::specCode_t'(4'($urandom_range(0, 11)));
    s.cram.cond   = 3'($urandom_range(0, 7));
    s.cram.condEn = 1'($urandom_range(0, 1));
    s.cram.magic  = 9'($urandom_range(0, 511));
    s.cram.arSel  = 3'($urandom_range(0, 7));
    s.cram.arxSel = 3'($urandom_range(0, 7));
    s.cram.mqEn   = 1'($urandom_range(0, 1));
    s.adIn        = randWord();
    s.memIn       = randWord();
    s.ebusIn      = randWord();
    return s;
  endfunction

  // Select codes: hold, adder, memory side, zero
  function automatic logic [0:Word-1] selSource(
    input logic [1:0]      code,
    input logic [0:Word-1] hold,
    input logic [0:Word-1] ad,
    input logic [0:Word-1] mem
  );
    if (code == 2'd0) return hold;
    if (code == 2'd1) return ad;
    if (code == 2'd2) return mem;
    return '0;
  endfunction

  task automatic checkVal(
    input string           name,
    input logic [0:Word-1] expVal,
    input logic [0:Word-1] actVal
  );
    if (actVal !== expVal) begin
      errCount++;
      $display("ERR %s %s expected %h actual %h", testName, name, expVal, actVal);
    end
  endtask

  // Reference model, one clock edge using the inputs in cur
  task automatic predict();
    eboxPkg::cramWord_t      c;
    logic [0:2]              cnd;
    logic                    ind;
    logic [0:2]              arF;
    logic                    console;
    logic [0:`EBOX_DIAG_W-1] dsel;
    logic                    rdEn;
    logic                    rd10x;
    logic                    diagLd;
    logic                    memAr;
    logic                    memArx;
    logic [1:0]              lCode;
    logic [1:0]              xCode;
    logic [1:0]              qCode;
    logic                    lClr;
    logic                    xClr;
    logic                    qClr;
    logic                    lLoad;
    logic                    rLoad;
    logic                    xLoad;
    logic                    pcReq;
    logic [0:Word-1]         arWord;
    logic [0:Word-1]         nextAr;
    logic [0:4]              grp;

    c   = cur.cram;
    cnd = c.condEn ? c.cond : 3'd0;
    ind = (cnd == 3'd6) || (c.spec == eboxPkg::specArlInd);
    arF = ind ? c.magic[6:8] : c.arSel;

    console = cur.ds[0] || cur.ds[1];
    dsel    = console ? cur.ds : c.magic[2:8];
    rdEn    = dsel[0] && cur.diagStrobe && (console || c.condEn);
    rd10x   = rdEn && (dsel[1:3] == 3'd0);
    diagLd  = rdEn && (cur.ds[1:3] == 3'b111) && (dsel[4:6] == 3'b111);

    memAr  = (cur.respMbox && cur.loadAr) || diagLd;
    memArx = cur.respMbox && cur.loadArx;

    if (memAr) lCode = 2'd2;
    else if (arF[1:2] == 2'd0) lCode = 2'd1;
    else lCode = arF[1:2];
    xCode = memArx ? 2'd2 : c.arxSel[1:2];

    if (cnd == 3'd7) qCode = c.magic[7:8];
    else if (c.spec == eboxPkg::specMqShift || c.disp == eboxPkg::dispMul ||
             c.disp == eboxPkg::dispDiv) qCode = 2'd2;
    else qCode = {1'b0, c.mqEn};

    lClr  = cnd == 3'd4;
    xClr  = c.arxSel[0] || (ind ? c.magic[3] : (cnd == 3'd5));
    qClr  = ind && c.magic[2];
    lLoad = !lClr && (memAr || cnd == 3'd1 || cnd == 3'd3 ||
                      (arF[1:2] != 2'd0 && !arF[0]));
    rLoad = !lClr && (memAr || cnd == 3'd2 || cnd == 3'd3 || arF[1:2] != 2'd0);
    xLoad = !xClr && (memArx || c.arxSel[1:2] != 2'd0);

    adLongM = c.disp == eboxPkg::dispMul || c.disp == eboxPkg::dispDiv ||
              c.disp == eboxPkg::dispNorm || c.spec == eboxPkg::specAdLong ||
              c.spec == eboxPkg::specMqShift;
    genCryM = c.spec == eboxPkg::specGenCry18 ||
              (c.spec == eboxPkg::specStackUpdate && cur.shortStack);
    pcReq   = c.spec == eboxPkg::specLoadPc || c.disp == eboxPkg::dispNicond;

    // Readback groups see the load register before this edge
    case (dsel[4:6])
      3'd0: grp = {c.spec == eboxPkg::specMqShift, c.spec == eboxPkg::specSaveFlags,
                   lCode[1], rLoad, lLoad};
      3'd1: grp = {c.spec == eboxPkg::specClrFpd, c.spec == eboxPkg::specMtrCtl,
                   lCode[0], rLoad, lLoad};
      3'd2: grp = {genCryM, diagLd, lCode[1], qCode[1], xLoad};
      3'd3: grp = {c.spec == eboxPkg::specStackUpdate, c.disp == eboxPkg::dispReturn,
                   lCode[0], qCode[0], xClr};
      3'd4: grp = {c.spec == eboxPkg::specFlagCtl, pcReq, xCode[1], qClr, lClr};
      3'd5: grp = {dregM.chanClkStop, dregM.forceExtend, xCode[0], qClr, lClr};
      3'd6: grp = {adLongM, dregM.diag4, xCode[1], c.mqEn, lClr};
      default: grp = {c.spec == eboxPkg::specInhCry18, dregM.memReset, xCode[0],
                      dregM.ldEbusReg, c.disp == eboxPkg::dispAread};
    endcase

    arWord = selSource(lCode, arM, cur.adIn, diagLd ? cur.ebusIn : cur.memIn);
    nextAr = arM;
    if (lClr) begin
      nextAr = '0;
    end else begin
      if (lLoad) nextAr[0 +: Half] = arWord[0 +: Half];
      if (rLoad) nextAr[Half +: Half] = arWord[Half +: Half];
    end
    arM = nextAr;

    if (xClr) arxM = '0;
    else if (xLoad) arxM = selSource(xCode, arxM, cur.adIn, cur.memIn);

    if (qClr) mqM = '0;
    else if (qCode == 2'd1) mqM = cur.adIn;
    else if (qCode == 2'd2) mqM = {mqM[1:Word-1], cur.adIn[0]};
    else if (qCode == 2'd3) mqM = '0;

    if (cur.diagStrobe && cur.ds == `EBOX_DIAG_LD076) begin
      dregM = cur.ebusIn[`EBOX_RB_LSB +: `EBOX_RB_W];
    end
    ebusOutM = '0;
    if (rd10x) ebusOutM[`EBOX_RB_LSB +: `EBOX_RB_W] = grp;
    ebusDrvM = rd10x;
    loadPcM  = pcReq && !loadPcM;
  endtask

  // Drive st on the rising edge, check on the falling edge
  task automatic runCycle();
    @(posedge CTL);
    cram       <= st.cram;
    adIn       <= st.adIn;
    memIn      <= st.memIn;
    loadAr     <= st.loadAr;
    loadArx    <= st.loadArx;
    respMbox   <= st.respMbox;
    shortStack <= st.shortStack;
    ds         <= st.ds;
    diagStrobe <= st.diagStrobe;
    ebusIn     <= st.ebusIn;
    cur = st;
    @(negedge CTL);
    checkVal("ar", arM, ar);
    checkVal("arx", arxM, arx);
    checkVal("mq", mqM, mq);
    checkVal("ebusOut", ebusOutM, ebusOut);
    checkVal("ebusDriving", widen(ebusDrvM), widen(ebusDriving));
    checkVal("loadPc", widen(loadPcM), widen(loadPc));
    predict();
    checkVal("adLong", widen(adLongM), widen(adLong));
    checkVal("genCry18", widen(genCryM), widen(genCry18));
  endtask

  task automatic waitForDrive();
    logic seen;
    seen = 1'b0;
    st = '0;
    for (int n = 0; n < DriveTimeout && !seen; n++) begin
      runCycle();
      seen = ebusDriving;
    end
    if (!seen) begin
      timeoutCount++;
      $display("Timeout in %s: bus data was never driven after the read", testName);
    end
  endtask

  task automatic endRun();
    $display("Run complete: %0d errors, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the test sequence completed");
    timeoutCount++;
    endRun();
  end

  initial begin
    void'($urandom(7));
    errCount     = 0;
    timeoutCount = 0;
    testName     = "reset";
    st           = '0;
    cur          = '0;
    arM          = '0;
    arxM         = '0;
    mqM          = '0;
    ebusOutM     = '0;
    ebusDrvM     = 1'b0;
    loadPcM      = 1'b0;
    adLongM      = 1'b0;
    genCryM      = 1'b0;
    dregM        = '0;
    reset      <= 1'b1;
    cram       <= '0;
    adIn       <= '0;
    memIn      <= '0;
    loadAr     <= 1'b0;
    loadArx    <= 1'b0;
    respMbox   <= 1'b0;
    shortStack <= 1'b0;
    ds         <= '0;
    diagStrobe <= 1'b0;
    ebusIn     <= '0;
    repeat (5) @(posedge CTL);
    reset <= 1'b0;
    runCycle();

    testName = "select";
    for (int i = 0; i < 300; i++) begin
      st = randStim();
      if (st.cram.cond == 3'd6) st.cram.cond = 3'd7;
      if (st.cram.spec == eboxPkg::specArlInd) st.cram.spec = eboxPkg::specNone;
      runCycle();
    end

    testName = "indirect";
    for (int i = 0; i < 150; i++) begin
      st = randStim();
      st.cram.condEn = 1'b1;
      st.cram.cond   = 3'd6;
      if (i % 4 == 0) st.cram.spec = eboxPkg::specMqShift;
      if (i % 4 == 1) begin
        st.cram.condEn = 1'b0;
        st.cram.spec   = eboxPkg::specArlInd;
      end
      runCycle();
    end

    // Every dispatch and special code, short stack both ways
    testName = "dispSpec";
    for (int d = 0; d < 8; d++) begin
      for (int s = 0; s < 12; s++) begin
        for (int k = 0; k < 2; k++) begin
          st = '0;
          st.cram.disp  = eboxPkg::dispCode_t'(3'(d));
          st.cram.spec  = eboxPkg::specCode_t'(4'(s));
          st.shortStack = 1'(k);
          runCycle();
        end
      end
    end

    testName = "diagRead";
    for (int g = 0; g < 8; g++) begin
      st = randStim();
      st.ds         = `EBOX_DIAG_LD076;
      st.diagStrobe = 1'b1;
      runCycle();
      st = randStim();
      st.ds         = {4'b1000, 3'(g)};
      st.diagStrobe = 1'b1;
      runCycle();
      waitForDrive();
      // Same group through the microcode path
      st = randStim();
      st.cram.condEn     = 1'b1;
      st.cram.magic[2:8] = {4'b1000, 3'(g)};
      st.diagStrobe      = 1'b1;
      runCycle();
      waitForDrive();
    end

    testName = "memResp";
    for (int i = 0; i < 150; i++) begin
      st = randStim();
      st.respMbox = 1'($urandom_range(0, 1));
      st.loadAr   = 1'($urandom_range(0, 1));
      st.loadArx  = 1'($urandom_range(0, 1));
      runCycle();
    end

    testName = "diagArLoad";
    for (int i = 0; i < 20; i++) begin
      st = randStim();
      st.cram.condEn = 1'b0;
      st.ds          = 7'o177;
      st.diagStrobe  = 1'b1;
      busWord        = st.ebusIn;
      runCycle();
      st = '0;
      runCycle();
      checkVal("arFromBus", busWord, ar);
    end

    endRun();
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/ebox_pkg.sv
ctl/ctlDecode.sv
ctl/ctlDiag.sv
hdl/arDatapath.sv
hdl/eboxCtl.sv
verif/eboxCtl_assert.sv
verif/eboxCtlTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= eboxCtlTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "$(TOP) reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "$(TOP) did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
